/* Makefile */
# Verilator flow for the tape deck: lint, simulate, clean
VERILATOR ?= verilator
TOP       ?= tb_tape_deck
RTL_TOP   ?= tape_deck_top
FILELIST  ?= tape_deck_top.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --timing --assert
PASS_MSG  ?= Verification passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

# Pass only when the simulation prints the pass line
sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

/* hdl/tape_activity_led.sv */
// Tape activity LED: breathing while playing, steady while paused, dark during download
`timescale 1ns/1ps

module tape_activity_led #(
    parameter int LED_CNT_W = 25
) (
    input  logic i_clk_28,
    input  logic i_reset,
    input  logic i_motor,
    input  logic i_dl_active,
    output logic o_led
);

    logic [LED_CNT_W-1:0] cnt;

    // Brightness ramps up in one half of the period and down in the other
    wire [7:0] level = cnt[LED_CNT_W-2 -: 8];
    wire [7:0] phase = cnt[7:0];
    wire       breathe = cnt[LED_CNT_W-1] ? (level > phase) : (level <= phase);

    always_ff @(posedge i_clk_28 or posedge i_reset) begin
        if (i_reset) begin
            cnt <= '0;
        end else begin
            cnt <= cnt + 1'b1;
        end
    end

    assign o_led = ~i_dl_active & (~i_motor | breathe);

endmodule

/* hdl/tape_buffer_ram.sv */
// Tape image buffer as a Wishbone classic slave of 16-bit words, instanced by the deck top
`timescale 1ns/1ps

module tape_buffer_ram import tape_pkg::*; #(
    parameter int MEM_WORDS_LOG2 = 12
) (
    input  logic    i_clk_28,
    input  logic    i_reset,
    input  wb_req_t i_wb,
    output wb_rsp_t o_wb
);

    tape_word_t mem [2**MEM_WORDS_LOG2];
    tape_word_t rd_data;
    logic       ack;

    // New request only, so each cycle is acked once
    wire                      req = i_wb.cyc & i_wb.stb & ~ack;
    wire [MEM_WORDS_LOG2-1:0] idx = i_wb.adr[MEM_WORDS_LOG2-1:0];

    always_ff @(posedge i_clk_28 or posedge i_reset) begin
        if (i_reset) begin
            ack <= 1'b0;
        end else begin
            ack <= req;
        end
    end

    // Byte lanes and registered read
    always_ff @(posedge i_clk_28) begin
        if (req && i_wb.we) begin
            if (i_wb.sel[1])
                mem[idx][15:8] <= i_wb.dat[15:8];
            if (i_wb.sel[0])
                mem[idx][7:0] <= i_wb.dat[7:0];
        end
        if (req)
            rd_data <= mem[idx];
    end

    assign o_wb = '{ack: ack, dat: rd_data};

    // Address must fit the configured depth
    a_adr_in_range: assert property (@(posedge i_clk_28) disable iff (i_reset)
        (i_wb.cyc && i_wb.stb) |-> ((i_wb.adr >> MEM_WORDS_LOG2) == '0))
        else $error("tape buffer address beyond depth: %h", i_wb.adr);

endmodule

/* hdl/tape_deck_top.sv */
// Tape path top: download into the buffer and byte feed to the external TZX player
`timescale 1ns/1ps

module tape_deck_top import tape_pkg::*; #(
    parameter int MEM_WORDS_LOG2 = 12,
    parameter int LED_CNT_W      = 25
) (
    input  logic       i_clk_28,
    input  logic       i_reset,
    input  dl_write_t  i_dl,
    input  logic       i_dl_active,
    input  logic       i_tzx_req,
    input  logic       i_loop_start,
    input  logic       i_loop_next,
    input  logic       i_stop,
    input  logic       i_pause_btn,
    output tape_byte_t o_tzx_byte,
    output logic       o_tzx_ack,
    output logic       o_motor,
    output logic       o_led
);

    // Byte read command between sequencer and fetch unit
    logic       rd_go;
    tape_addr_t rd_addr;
    logic       rd_done;
    tape_byte_t rd_byte;

    // Buffer bus
    wb_req_t    wb_req;
    wb_rsp_t    wb_rsp;

    tape_sequencer u_tape_sequencer (
        .i_clk_28     (i_clk_28),
        .i_reset      (i_reset),
        .i_dl         (i_dl),
        .i_dl_active  (i_dl_active),
        .i_tzx_req    (i_tzx_req),
        .i_loop_start (i_loop_start),
        .i_loop_next  (i_loop_next),
        .i_stop       (i_stop),
        .i_pause_btn  (i_pause_btn),
        .i_rd_done    (rd_done),
        .i_rd_byte    (rd_byte),
        .o_rd_go      (rd_go),
        .o_rd_addr    (rd_addr),
        .o_tzx_byte   (o_tzx_byte),
        .o_tzx_ack    (o_tzx_ack),
        .o_motor      (o_motor)
    );

    tape_word_fetch u_tape_word_fetch (
        .i_clk_28    (i_clk_28),
        .i_reset     (i_reset),
        .i_dl        (i_dl),
        .i_dl_active (i_dl_active),
        .i_rd_go     (rd_go),
        .i_rd_addr   (rd_addr),
        .i_wb        (wb_rsp),
        .o_wb        (wb_req),
        .o_rd_done   (rd_done),
        .o_rd_byte   (rd_byte)
    );

    tape_buffer_ram #(.MEM_WORDS_LOG2(MEM_WORDS_LOG2)) u_tape_buffer_ram (
        .i_clk_28 (i_clk_28),
        .i_reset  (i_reset),
        .i_wb     (wb_req),
        .o_wb     (wb_rsp)
    );

    tape_activity_led #(.LED_CNT_W(LED_CNT_W)) u_tape_activity_led (
        .i_clk_28    (i_clk_28),
        .i_reset     (i_reset),
        .i_motor     (o_motor),
        .i_dl_active (i_dl_active),
        .o_led       (o_led)
    );

endmodule

/* hdl/tape_pkg.sv */
// Shared tape types and bus structs, imported by every tape path module and the testbench
package tape_pkg;

    // ======================================================================
    // Tape addressing and data
    // ======================================================================

    // Byte address width of the tape image
    localparam int TAPE_ADDR_W = 24;

    typedef logic [TAPE_ADDR_W-1:0] tape_addr_t;
    typedef logic [7:0]             tape_byte_t;

    // Even byte in the high half, odd byte in the low half
    typedef logic [15:0]            tape_word_t;

    // Byte address with bit 0 dropped
    typedef logic [TAPE_ADDR_W-2:0] tape_waddr_t;

    // One byte from the host download
    typedef struct packed {
        logic       wr;
        tape_addr_t addr;
        tape_byte_t data;
    } dl_write_t;

    // ======================================================================
    // Wishbone classic, buffer side
    // ======================================================================

    // Master outputs
    typedef struct packed {
        logic        cyc;
        logic        stb;
        logic        we;
        logic [1:0]  sel;
        tape_waddr_t adr;
        tape_word_t  dat;
    } wb_req_t;

    // Slave outputs, read data valid with ack
    typedef struct packed {
        logic       ack;
        tape_word_t dat;
    } wb_rsp_t;

endpackage

/* hdl/tape_sequencer.sv */
// Tape play position, loop point and pause state, answering the player toggle handshake
`timescale 1ns/1ps

module tape_sequencer import tape_pkg::*; (
    input  logic       i_clk_28,
    input  logic       i_reset,
    input  dl_write_t  i_dl,
    input  logic       i_dl_active,
    input  logic       i_tzx_req,
    input  logic       i_loop_start,
    input  logic       i_loop_next,
    input  logic       i_stop,
    input  logic       i_pause_btn,
    input  logic       i_rd_done,
    input  tape_byte_t i_rd_byte,
    output logic       o_rd_go,
    output tape_addr_t o_rd_addr,
    output tape_byte_t o_tzx_byte,
    output logic       o_tzx_ack,
    output logic       o_motor
);

    tape_addr_t play_addr;
    tape_addr_t last_addr;
    tape_addr_t loop_addr;
    logic       paused;
    logic       rd_busy;
    logic       req_q;
    logic       loop_start_q;
    logic       loop_next_q;
    logic       stop_q;
    logic       pause_btn_q;

    // Request stays pending until ack catches up, also across a pause
    wire        req_pend = req_q ^ o_tzx_ack;
    wire        at_end   = play_addr == last_addr + 1'b1;

    always_ff @(posedge i_clk_28 or posedge i_reset) begin
        if (i_reset) begin
            play_addr    <= '0;
            last_addr    <= '0;
            loop_addr    <= '0;
            paused       <= 1'b1;
            rd_busy      <= 1'b0;
            o_rd_go      <= 1'b0;
            o_tzx_ack    <= 1'b0;
            req_q        <= 1'b0;
            loop_start_q <= 1'b0;
            loop_next_q  <= 1'b0;
            stop_q       <= 1'b0;
            pause_btn_q  <= 1'b0;
        end else begin
            req_q        <= i_tzx_req;
            loop_start_q <= i_loop_start;
            loop_next_q  <= i_loop_next;
            stop_q       <= i_stop;
            pause_btn_q  <= i_pause_btn;
            o_rd_go      <= 1'b0;

            if (i_dl_active) begin
                play_addr <= '0;
                loop_addr <= '0;
                paused    <= 1'b1;
                if (i_dl.wr)
                    last_addr <= i_dl.addr;
            end else begin
                if (req_pend && !rd_busy && !paused) begin
                    if (at_end) begin
                        paused <= 1'b1;
                    end else begin
                        o_rd_go <= 1'b1;
                        rd_busy <= 1'b1;
                    end
                end
                if (i_rd_done) begin
                    rd_busy   <= 1'b0;
                    o_tzx_ack <= ~o_tzx_ack;
                    play_addr <= play_addr + 1'b1;
                end

                // Player controls and button, rising edges only
                if (i_stop && !stop_q)
                    paused <= 1'b1;
                if (i_loop_start && !loop_start_q)
                    loop_addr <= play_addr;
                if (i_loop_next && !loop_next_q)
                    play_addr <= loop_addr;
                if (i_pause_btn && !pause_btn_q)
                    paused <= ~paused;
            end
        end
    end

    always_ff @(posedge i_clk_28) begin
        if (i_rd_done)
            o_tzx_byte <= i_rd_byte;
    end

    assign o_rd_addr = play_addr;
    assign o_motor   = ~paused;

    // Player waits for the ack before toggling again
    a_one_req: assert property (@(posedge i_clk_28) disable iff (i_reset)
        $changed(i_tzx_req) |-> (i_tzx_req != o_tzx_ack))
        else $error("player toggled request before ack");

endmodule

/* hdl/tape_word_fetch.sv */
// Wishbone master that stores download bytes and serves player byte reads, instanced by the deck top
`timescale 1ns/1ps

module tape_word_fetch import tape_pkg::*; (
    input  logic       i_clk_28,
    input  logic       i_reset,
    input  dl_write_t  i_dl,
    input  logic       i_dl_active,
    input  logic       i_rd_go,
    input  tape_addr_t i_rd_addr,
    input  wb_rsp_t    i_wb,
    output wb_req_t    o_wb,
    output logic       o_rd_done,
    output tape_byte_t o_rd_byte
);

    logic        bus_cyc;
    logic        bus_we;
    logic [1:0]  bus_sel;
    tape_waddr_t bus_adr;
    tape_word_t  bus_dat;
    logic        rd_pend;
    logic        rd_lsb;
    tape_word_t  held_word;
    tape_waddr_t held_waddr;
    logic        held_valid;

    wire dl_stb = i_dl.wr & i_dl_active;
    wire hit    = held_valid && (held_waddr == i_rd_addr[TAPE_ADDR_W-1:1]);

    // ======================================================================
    // Bus cycle and held word control
    // ======================================================================
    always_ff @(posedge i_clk_28 or posedge i_reset) begin
        if (i_reset) begin
            bus_cyc    <= 1'b0;
            rd_pend    <= 1'b0;
            held_valid <= 1'b0;
            o_rd_done  <= 1'b0;
        end else begin
            o_rd_done <= 1'b0;
            if (bus_cyc) begin
                if (i_wb.ack) begin
                    bus_cyc <= 1'b0;
                    if (rd_pend) begin
                        rd_pend    <= 1'b0;
                        held_valid <= 1'b1;
                        o_rd_done  <= 1'b1;
                    end
                end
            end else if (dl_stb) begin
                bus_cyc <= 1'b1;
            end else if (i_rd_go) begin
                if (hit) begin
                    o_rd_done <= 1'b1;
                end else begin
                    bus_cyc <= 1'b1;
                    rd_pend <= 1'b1;
                end
            end
            // Held word goes stale once the image changes
            if (dl_stb)
                held_valid <= 1'b0;
        end
    end

    // Bus fields and returned bytes
    always_ff @(posedge i_clk_28) begin
        if (!bus_cyc && dl_stb) begin
            bus_we  <= 1'b1;
            bus_sel <= i_dl.addr[0] ? 2'b01 : 2'b10;
            bus_adr <= i_dl.addr[TAPE_ADDR_W-1:1];
            bus_dat <= {i_dl.data, i_dl.data};
        end else if (!bus_cyc && i_rd_go) begin
            bus_we  <= 1'b0;
            bus_sel <= 2'b11;
            bus_adr <= i_rd_addr[TAPE_ADDR_W-1:1];
            rd_lsb  <= i_rd_addr[0];
            if (hit)
                o_rd_byte <= i_rd_addr[0] ? held_word[7:0] : held_word[15:8];
        end
        if (bus_cyc && i_wb.ack && rd_pend) begin
            held_word  <= i_wb.dat;
            held_waddr <= bus_adr;
            o_rd_byte  <= rd_lsb ? i_wb.dat[7:0] : i_wb.dat[15:8];
        end
    end

    assign o_wb = '{cyc: bus_cyc, stb: bus_cyc, we: bus_we, sel: bus_sel,
                    adr: bus_adr, dat: bus_dat};

    // Host strobes leave room for a full bus cycle
    a_dl_spacing: assert property (@(posedge i_clk_28) disable iff (i_reset)
        dl_stb |=> !dl_stb [*3])
        else $error("download strobes closer than 4 cycles");

    // Strobe stays inside cyc with the request unchanged until the slave acks
    a_stb_in_cyc: assert property (@(posedge i_clk_28) disable iff (i_reset)
        (o_wb.stb && !i_wb.ack) |=> (o_wb.stb && o_wb.cyc && $stable(o_wb)))
        else $error("wishbone request dropped or changed before ack");

endmodule

/* sim/tb_tape_tasks.svh */
// Testbench helpers for the tape deck: image generator, drivers, ack waits and typed compares
`ifndef TB_TAPE_TASKS_SVH
`define TB_TAPE_TASKS_SVH

// ======================================================================
// Stimulus
// ======================================================================

// LCG step, the top byte is the best mixed
function automatic tape_byte_t random_byte();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state[31:24];
endfunction

task automatic make_image();
    for (int i = 0; i < IMAGE_LEN; i++)
        image[i] = random_byte();
endtask

// One strobe per byte, 5 cycles apart
task automatic download_image();
    dl_active = 1'b1;
    for (int i = 0; i < IMAGE_LEN; i++) begin
        dl = '{wr: 1'b1, addr: tape_addr_t'(i), data: image[i]};
        @(negedge clk_28);
        dl.wr = 1'b0;
        // LED dark and deck paused while the host writes
        check_bit("o_led", led, 1'b0);
        check_bit("o_motor", motor, 1'b0);
        repeat (4) @(negedge clk_28);
    end
    dl_active = 1'b0;
    @(negedge clk_28);
endtask

// Single-cycle high pulse on one control lane
task automatic pulse_control(input int lane);
    ctrl[lane] = 1'b1;
    @(negedge clk_28);
    ctrl[lane] = 1'b0;
    @(negedge clk_28);
endtask

// ======================================================================
// Handshake
// ======================================================================

// Poll on falling edges until ack catches up with req
task automatic wait_ack(output logic acked);
    acked = 1'b0;
    for (int n = 0; n < ACK_TIMEOUT && !acked; n++) begin
        @(negedge clk_28);
        acked = (tzx_ack == tzx_req);
    end
endtask

// Byte for a request already toggled
task automatic collect_byte(input int addr);
    logic acked;
    wait_ack(acked);
    if (!acked) begin
        $display("Timeout: no ack for the byte at address %0d", addr);
        error_count++;
    end else begin
        check_byte("o_tzx_byte", tzx_byte, image[addr]);
    end
endtask

task automatic read_expect(input int addr);
    tzx_req = ~tzx_req;
    collect_byte(addr);
endtask

// Request that must stay unanswered
task automatic expect_no_ack();
    logic acked;
    tzx_req = ~tzx_req;
    wait_ack(acked);
    check_count++;
    if (acked) begin
        $display("Error: request was acknowledged while the deck should be stopped");
        error_count++;
    end
endtask

// ======================================================================
// Compares and reporting
// ======================================================================

task automatic check_byte(input string name, input tape_byte_t got, input tape_byte_t exp);
    check_count++;
    if (got !== exp) begin
        $display("Fail %s: got %h, expected %h", name, got, exp);
        error_count++;
    end
endtask

task automatic check_bit(input string name, input logic got, input logic exp);
    check_count++;
    if (got !== exp) begin
        $display("Fail %s: got %h, expected %h", name, got, exp);
        error_count++;
    end
endtask

task automatic start_test();
    test_count++;
    test_first_error = error_count;
endtask

task automatic end_test(input string name);
    $display("Test %0d, %s: %0d errors", test_count, name, error_count - test_first_error);
endtask

`endif

/* sim/tb_tape_deck.sv */
// Directed testbench for the tape deck top that downloads an image and plays it back by handshake
`timescale 1ns/1ps

module tb_tape_deck import tape_pkg::*; ();

    localparam int IMAGE_LEN   = 13;
    localparam int ACK_TIMEOUT = 60;

    // Lanes of the control pulse vector
    localparam int CTRL_LOOP_START = 0;
    localparam int CTRL_LOOP_NEXT  = 1;
    localparam int CTRL_STOP       = 2;
    localparam int CTRL_PAUSE      = 3;

    logic       clk_28;
    logic       reset;
    dl_write_t  dl;
    logic       dl_active;
    logic       tzx_req;
    logic [3:0] ctrl;
    tape_byte_t tzx_byte;
    logic       tzx_ack;
    logic       motor;
    logic       led;

    // Image model and its generator state
    tape_byte_t  image [IMAGE_LEN];
    logic [31:0] lcg_state;

    int error_count;
    int check_count;
    int test_count;
    int test_first_error;

    tape_deck_top #(
        .MEM_WORDS_LOG2 (10),
        .LED_CNT_W      (12)
    ) i_tape_deck_top (
        .i_clk_28     (clk_28),
        .i_reset      (reset),
        .i_dl         (dl),
        .i_dl_active  (dl_active),
        .i_tzx_req    (tzx_req),
        .i_loop_start (ctrl[CTRL_LOOP_START]),
        .i_loop_next  (ctrl[CTRL_LOOP_NEXT]),
        .i_stop       (ctrl[CTRL_STOP]),
        .i_pause_btn  (ctrl[CTRL_PAUSE]),
        .o_tzx_byte   (tzx_byte),
        .o_tzx_ack    (tzx_ack),
        .o_motor      (motor),
        .o_led        (led)
    );

    initial begin
        clk_28 = 1'b0;
        forever #20 clk_28 = ~clk_28;
    end

    `include "tb_tape_tasks.svh"

    // ======================================================================
    // Directed tests
    // ======================================================================

    task automatic test_download_play();
        start_test();
        check_bit("o_motor", motor, 1'b0);
        check_bit("o_tzx_ack", tzx_ack, 1'b0);
        // Deck running before the host starts, so the download must pause it
        pulse_control(CTRL_PAUSE);
        check_bit("o_motor", motor, 1'b1);
        make_image();
        download_image();
        // Download leaves the deck paused
        pulse_control(CTRL_PAUSE);
        check_bit("o_motor", motor, 1'b1);
        for (int a = 0; a < IMAGE_LEN; a++)
            read_expect(a);
        end_test("download then play");
    endtask

    task automatic test_end_of_image();
        start_test();
        expect_no_ack();
        check_bit("o_motor", motor, 1'b0);
        check_bit("o_led", led, 1'b1);
        end_test("end of image");
    endtask

    // Request left over from the end is served from address 0 of a fresh image
    task automatic test_pause_resume();
        start_test();
        make_image();
        download_image();
        check_bit("o_tzx_ack", tzx_ack, ~tzx_req);
        pulse_control(CTRL_PAUSE);
        collect_byte(0);
        for (int a = 1; a < 4; a++)
            read_expect(a);
        pulse_control(CTRL_PAUSE);
        check_bit("o_motor", motor, 1'b0);
        expect_no_ack();
        pulse_control(CTRL_PAUSE);
        check_bit("o_motor", motor, 1'b1);
        collect_byte(4);
        end_test("pause and resume");
    endtask

    // Play position is 5 here
    task automatic test_loop();
        start_test();
        pulse_control(CTRL_LOOP_START);
        for (int a = 5; a < 9; a++)
            read_expect(a);
        pulse_control(CTRL_LOOP_NEXT);
        for (int a = 5; a < 9; a++)
            read_expect(a);
        end_test("loop");
    endtask

    task automatic test_stop();
        start_test();
        read_expect(9);
        pulse_control(CTRL_STOP);
        check_bit("o_motor", motor, 1'b0);
        expect_no_ack();
        end_test("stop");
    endtask

    initial begin
        reset       = 1'b1;
        dl          = '0;
        dl_active   = 1'b0;
        tzx_req     = 1'b0;
        ctrl        = '0;
        lcg_state   = 32'hee00_3372;
        error_count = 0;
        check_count = 0;
        test_count  = 0;
        repeat (8) @(negedge clk_28);
        reset = 1'b0;
        repeat (2) @(negedge clk_28);

        test_download_play();
        test_end_of_image();
        test_pause_resume();
        test_loop();
        test_stop();

        $display("Summary: %0d tests, %0d checks, %0d errors",
                 test_count, check_count, error_count);
        if (error_count == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

/* tape_deck_top.f */
+incdir+sim
hdl/tape_pkg.sv
hdl/tape_buffer_ram.sv
hdl/tape_word_fetch.sv
hdl/tape_sequencer.sv
hdl/tape_activity_led.sv
hdl/tape_deck_top.sv
sim/tb_tape_deck.sv
